//--- rv_core_defs.svh
////////////////////
// RV32I core slice widths, memory depth and reset PC
////////////////////
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data word and PC width
`define XLEN 32

// Instruction memory address width in words
`define IMEM_AW 6

// Register index width
`define REG_AW 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- rv_pkg.sv
////////////////////
// RV32I core slice types
// ALU op encoding and the three stage payloads
////////////////////
`include "rv_core_defs.svh"

package rv_pkg;

	// ALU operation select
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		ALU_SLL    = 4'd6,
		ALU_SRL    = 4'd7,
		// LUI goes through here
		ALU_PASS_B = 4'd8
	} alu_op_e;

	// Fetch to decode
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] inst;
	} if_id_t;

	// Decode to execute
	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		// Operands after forwarding
		logic [`XLEN-1:0]   op_a;
		logic [`XLEN-1:0]   op_b;
		logic [`XLEN-1:0]   imm;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		alu_op_e            alu_op;
		// Immediate replaces operand b
		logic               sel_imm;
		logic               is_branch;
		// BNE when set, BEQ otherwise
		logic               branch_ne;
		logic               wr_en;
	} id_exe_t;

	// Execute to writeback
	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   result;
		logic               wr_en;
	} exe_wb_t;

endpackage

//--- wb_if.sv
////////////////////
// Register write bus
// Shared by EXE forwarding and writeback
////////////////////
`timescale 1ns/1ps
`include "rv_core_defs.svh"

interface wb_if;
	logic               valid;
	logic [`REG_AW-1:0] rd;
	logic [`XLEN-1:0]   data;
	// Instruction address for trace
	logic [`XLEN-1:0]   pc;

	// Producer side
	modport src (output valid, output rd, output data, output pc);
	// Consumer side
	modport dst (input valid, input rd, input data, input pc);
endinterface

//--- stage_reg.sv
////////////////////
// Pipeline stage register
// Any payload, with stall, flush and valid bit
////////////////////
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     stall,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else if (flush) begin
			// Flush wins over stall
			out_valid <= 1'b0;
			out_data  <= '0;
		end else if (!stall) begin
			out_valid <= in_valid;
			out_data  <= in_data;
		end
		// Stalled: hold valid and payload
	end

endmodule

//--- fetch_unit.sv
////////////////////
// Fetch unit
// Instruction memory, load port and PC sequencing
////////////////////
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module fetch_unit (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                run,
	input  logic                redirect_valid,
	input  logic [`XLEN-1:0]    redirect_pc,
	input  logic                load_req,
	input  logic [`IMEM_AW-1:0] load_addr,
	input  logic [`XLEN-1:0]    load_data,
	output logic                load_ack,
	output logic [`XLEN-1:0]    pc,
	output logic [`XLEN-1:0]    inst,
	output logic                inst_valid
);

	localparam int IMEM_WORDS = 1 << `IMEM_AW;
	localparam logic [`XLEN-1:0] PC_STEP = 4;

	logic [`XLEN-1:0] imem [0:IMEM_WORDS-1];
	logic             load_we;
	logic             pc_in_range;

	// Write only in the request phase and only while halted
	// Requests during run wait here with no ack
	assign load_we = load_req & ~load_ack & ~run;

	always_ff @(posedge clk) begin
		if (load_we) begin
			imem[load_addr] <= load_data;
		end
	end

	// Four-phase ack
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load_ack <= 1'b0;
		end else if (load_we) begin
			load_ack <= 1'b1;
		end else if (!load_req) begin
			// Host dropped req, finish the handshake
			load_ack <= 1'b0;
		end
	end

	// PC advances only while running
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `RESET_PC;
		end else if (run) begin
			if (redirect_valid) begin
				// Taken branch in EXE
				pc <= redirect_pc;
			end else begin
				pc <= pc + PC_STEP;
			end
		end
	end

	// Upper PC bits must be clear to hit memory
	assign pc_in_range = (pc[`XLEN-1:`IMEM_AW+2] == '0);

	// Combinational read, IF/ID captures it
	assign inst = imem[pc[`IMEM_AW+1:2]];

	// Out of range PC turns into bubbles
	assign inst_valid = run & pc_in_range;

endmodule

//--- decode_stage.sv
////////////////////
// Decode stage
// Decoder, register file and operand forwarding
////////////////////
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module decode_stage import rv_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    in_valid,
	input  if_id_t  in_data,
	wb_if.dst       exe_fwd,
	wb_if.dst       wb,
	output logic    out_valid,
	output id_exe_t out_data
);

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic [`XLEN-1:0]             rf [0:(1<<`REG_AW)-1];
	logic [6:0]                   opcode;
	logic [2:0]                   funct3;
	logic [6:0]                   funct7;
	logic [1:0][`REG_AW-1:0]      rs_idx;
	logic [1:0][`XLEN-1:0]        rs_val;
	logic [`XLEN-1:0]             imm_i;
	logic [`XLEN-1:0]             imm_u;
	logic [`XLEN-1:0]             imm_b;
	logic                         legal;

	assign opcode = in_data.inst[6:0];
	assign funct3 = in_data.inst[14:12];
	assign funct7 = in_data.inst[31:25];
	assign rs_idx = {in_data.inst[24:20], in_data.inst[19:15]};

	// Immediate formats
	assign imm_i = {{(`XLEN-12){in_data.inst[31]}}, in_data.inst[31:20]};
	assign imm_u = {in_data.inst[31:12], 12'b0};
	assign imm_b = {{(`XLEN-13){in_data.inst[31]}}, in_data.inst[31], in_data.inst[7],
		in_data.inst[30:25], in_data.inst[11:8], 1'b0};

	// Writeback port, x0 never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < (1 << `REG_AW); i++) begin
				rf[i] <= '0;
			end
		end else if (wb.valid && wb.rd != '0) begin
			rf[wb.rd] <= wb.data;
		end
	end

	// Operand read: EXE result, then WB, then register file
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			if (rs_idx[k] == '0) begin
				rs_val[k] = '0;
			end else if (exe_fwd.valid && exe_fwd.rd == rs_idx[k]) begin
				rs_val[k] = exe_fwd.data;
			end else if (wb.valid && wb.rd == rs_idx[k]) begin
				rs_val[k] = wb.data;
			end else begin
				rs_val[k] = rf[rs_idx[k]];
			end
		end
	end

	always_comb begin
		out_data        = '0;
		out_data.pc     = in_data.pc;
		out_data.op_a   = rs_val[0];
		out_data.op_b   = rs_val[1];
		out_data.rd     = in_data.inst[11:7];
		out_data.rs1    = rs_idx[0];
		out_data.rs2    = rs_idx[1];
		out_data.alu_op = ALU_ADD;
		legal           = 1'b0;
		case (opcode)
			OPC_OP: begin
				// Only SUB uses the alternate funct7
				legal = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
				out_data.wr_en = 1'b1;
				case (funct3)
					3'b000: out_data.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
					3'b111: out_data.alu_op = ALU_AND;
					3'b110: out_data.alu_op = ALU_OR;
					3'b100: out_data.alu_op = ALU_XOR;
					3'b010: out_data.alu_op = ALU_SLT;
					3'b001: out_data.alu_op = ALU_SLL;
					3'b101: out_data.alu_op = ALU_SRL;
					default: legal = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				legal            = 1'b1;
				out_data.wr_en   = 1'b1;
				out_data.sel_imm = 1'b1;
				out_data.imm     = imm_i;
				case (funct3)
					3'b000: out_data.alu_op = ALU_ADD;
					3'b111: out_data.alu_op = ALU_AND;
					3'b110: out_data.alu_op = ALU_OR;
					3'b100: out_data.alu_op = ALU_XOR;
					3'b010: out_data.alu_op = ALU_SLT;
					// Shift immediates not supported
					default: legal = 1'b0;
				endcase
			end
			OPC_LUI: begin
				legal            = 1'b1;
				out_data.wr_en   = 1'b1;
				out_data.sel_imm = 1'b1;
				out_data.imm     = imm_u;
				out_data.alu_op  = ALU_PASS_B;
			end
			OPC_BRANCH: begin
				// BEQ and BNE only
				legal              = (funct3 == 3'b000) || (funct3 == 3'b001);
				out_data.is_branch = 1'b1;
				out_data.branch_ne = funct3[0];
				out_data.imm       = imm_b;
			end
			default: legal = 1'b0;
		endcase
	end

	// Unknown opcodes become bubbles
	assign out_valid = in_valid & legal;

endmodule

//--- exec_stage.sv
////////////////////
// Execute stage
// ALU, branch compare and forwarding source
////////////////////
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module exec_stage import rv_pkg::*; (
	input  logic             in_valid,
	input  id_exe_t          in_data,
	output logic             out_valid,
	output exe_wb_t          out_data,
	wb_if.src                fwd,
	output logic             redirect_valid,
	output logic [`XLEN-1:0] redirect_pc
);

	logic [`XLEN-1:0] op_b_eff;
	logic [`XLEN-1:0] alu_res;
	logic [4:0]       shamt;
	logic             slt_res;
	logic             equal;

	assign op_b_eff = in_data.sel_imm ? in_data.imm : in_data.op_b;
	assign shamt    = op_b_eff[4:0];
	// Signed compare for SLT and SLTI
	assign slt_res  = $signed(in_data.op_a) < $signed(op_b_eff);

	always_comb begin
		case (in_data.alu_op)
			ALU_ADD:    alu_res = in_data.op_a + op_b_eff;
			ALU_SUB:    alu_res = in_data.op_a - op_b_eff;
			ALU_AND:    alu_res = in_data.op_a & op_b_eff;
			ALU_OR:     alu_res = in_data.op_a | op_b_eff;
			ALU_XOR:    alu_res = in_data.op_a ^ op_b_eff;
			ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, slt_res};
			ALU_SLL:    alu_res = in_data.op_a << shamt;
			ALU_SRL:    alu_res = in_data.op_a >> shamt;
			ALU_PASS_B: alu_res = op_b_eff;
			default:    alu_res = '0;
		endcase
	end

	// Branches compare the two registers, never the immediate
	assign equal          = (in_data.op_a == in_data.op_b);
	assign redirect_valid = in_valid & in_data.is_branch & (equal ^ in_data.branch_ne);
	assign redirect_pc    = in_data.pc + in_data.imm;

	// Branches carry wr_en low into EXE/WB
	assign out_valid       = in_valid;
	assign out_data.pc     = in_data.pc;
	assign out_data.rd     = in_data.rd;
	assign out_data.result = alu_res;
	assign out_data.wr_en  = in_data.wr_en;

	// Distance-one forwarding into decode
	assign fwd.valid = in_valid & in_data.wr_en;
	assign fwd.rd    = in_data.rd;
	assign fwd.data  = alu_res;
	assign fwd.pc    = in_data.pc;

endmodule

//--- rv_core_top.sv
////////////////////
// RV32I pipeline slice top
// Fetch, decode, execute and writeback with trace
////////////////////
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_top import rv_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                run,
	input  logic                load_req,
	input  logic [`IMEM_AW-1:0] load_addr,
	input  logic [`XLEN-1:0]    load_data,
	output logic                load_ack,
	output logic                trace_valid,
	output logic [`XLEN-1:0]    trace_pc,
	output logic [`REG_AW-1:0]  trace_rd,
	output logic [`XLEN-1:0]    trace_data
);

	logic             stall;
	logic             flush_front;
	logic [`XLEN-1:0] fetch_pc;
	logic [`XLEN-1:0] fetch_inst;
	logic             fetch_valid;
	logic             redirect_valid;
	logic [`XLEN-1:0] redirect_pc;
	if_id_t           if_id_in;
	if_id_t           if_id_q;
	logic             if_id_valid;
	id_exe_t          id_exe_in;
	id_exe_t          id_exe_q;
	logic             id_exe_in_valid;
	logic             id_exe_valid;
	exe_wb_t          exe_wb_in;
	exe_wb_t          exe_wb_q;
	logic             exe_wb_in_valid;
	logic             exe_wb_valid;

	wb_if exe_fwd ();
	wb_if wb ();

	// run low freezes every stage
	assign stall = ~run;
	// Stalled branch must stay in EXE until it can redirect
	assign flush_front = redirect_valid & run;

	fetch_unit u_fetch (
		.clk, .arst_n, .run, .redirect_valid, .redirect_pc,
		.load_req, .load_addr, .load_data, .load_ack,
		.pc(fetch_pc), .inst(fetch_inst), .inst_valid(fetch_valid)
	);

	assign if_id_in.pc   = fetch_pc;
	assign if_id_in.inst = fetch_inst;

	stage_reg #(.payload_t(if_id_t)) u_if_id (
		.clk, .arst_n, .stall, .flush(flush_front),
		.in_valid(fetch_valid), .in_data(if_id_in),
		.out_valid(if_id_valid), .out_data(if_id_q)
	);

	decode_stage u_decode (
		.clk, .arst_n, .in_valid(if_id_valid), .in_data(if_id_q),
		.exe_fwd, .wb, .out_valid(id_exe_in_valid), .out_data(id_exe_in)
	);

	stage_reg #(.payload_t(id_exe_t)) u_id_exe (
		.clk, .arst_n, .stall, .flush(flush_front),
		.in_valid(id_exe_in_valid), .in_data(id_exe_in),
		.out_valid(id_exe_valid), .out_data(id_exe_q)
	);

	exec_stage u_exec (
		.in_valid(id_exe_valid), .in_data(id_exe_q),
		.out_valid(exe_wb_in_valid), .out_data(exe_wb_in),
		.fwd(exe_fwd), .redirect_valid, .redirect_pc
	);

	// Nothing younger than EXE/WB ever needs flushing here
	stage_reg #(.payload_t(exe_wb_t)) u_exe_wb (
		.clk, .arst_n, .stall, .flush(1'b0),
		.in_valid(exe_wb_in_valid), .in_data(exe_wb_in),
		.out_valid(exe_wb_valid), .out_data(exe_wb_q)
	);

	// Retire once, on the cycle EXE/WB advances
	assign wb.valid = exe_wb_valid & exe_wb_q.wr_en & run;
	assign wb.rd    = exe_wb_q.rd;
	assign wb.data  = exe_wb_q.result;
	assign wb.pc    = exe_wb_q.pc;

	assign trace_valid = wb.valid;
	assign trace_pc    = wb.pc;
	assign trace_rd    = wb.rd;
	assign trace_data  = wb.data;

endmodule

//--- tb_clock.sv
////////////////////
// Testbench clock and reset
////////////////////
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 4
) (
	input  logic rst_req,
	output logic clk,
	output logic arst_n
);

	logic rst_init;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Power-on reset for two cycles, released off the edge
	initial begin
		rst_init = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst_init = 1'b0;
	end

	assign arst_n = ~(rst_init | rst_req);

endmodule

//--- tb_rv_core.sv
////////////////////
// RV32I core slice testbench
// Loads programs, runs them and checks the trace against an ISA model
////////////////////
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_rv_core;

	localparam int ACK_TIMEOUT  = 20;
	localparam int RUN_TIMEOUT  = 2000;
	localparam int DRAIN_CYCLES = 6;
	localparam int HOLD_CYCLES  = 5;
	// BEQ x0, x0, 0
	localparam logic [31:0] SELF_LOOP = 32'h0000_0063;

	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   data;
	} trace_rec_t;

	logic                clk;
	logic                arst_n;
	logic                rst_req;
	logic                run;
	logic                load_req;
	logic [`IMEM_AW-1:0] load_addr;
	logic [`XLEN-1:0]    load_data;
	logic                load_ack;
	logic                trace_valid;
	logic [`XLEN-1:0]    trace_pc;
	logic [`REG_AW-1:0]  trace_rd;
	logic [`XLEN-1:0]    trace_data;

	logic [31:0] prog [0:(1<<`IMEM_AW)-1];
	int          prog_len;
	trace_rec_t  expected_q [$];
	trace_rec_t  head;
	string       test_name;
	int          trace_errors;
	int          protocol_errors;
	int          timeout_errors;
	logic [31:0] lfsr_state = 32'hf9e6b023;

	tb_clock u_clock (.rst_req, .clk, .arst_n);

	rv_core_top u_rv_core_top (
		.clk, .arst_n, .run, .load_req, .load_addr, .load_data, .load_ack,
		.trace_valid, .trace_pc, .trace_rd, .trace_data
	);

	// One Galois step per bit
	function automatic logic lfsr_step();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) lfsr_state = lfsr_state ^ 32'h8020_0003;
		return lsb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	// Instruction encoders
	function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [2:0] f3,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// LUI then ADDI gives a random full word
	task automatic emit_init(input logic [4:0] rd);
		emit(lui_word(20'(rand_bits(20)), rd));
		emit(i_type_word(12'(rand_bits(12)), 3'b000, rd, rd));
	endtask

	task automatic emit_random_op(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		int          sel;
		logic [11:0] imm;
		sel = int'(rand_bits(4) % 13);
		imm = 12'(rand_bits(12));
		case (sel)
			0: emit(r_type_word(7'h00, 3'b000, rd, rs1, rs2));
			1: emit(r_type_word(7'h20, 3'b000, rd, rs1, rs2));
			2: emit(r_type_word(7'h00, 3'b111, rd, rs1, rs2));
			3: emit(r_type_word(7'h00, 3'b110, rd, rs1, rs2));
			4: emit(r_type_word(7'h00, 3'b100, rd, rs1, rs2));
			5: emit(r_type_word(7'h00, 3'b010, rd, rs1, rs2));
			6: emit(r_type_word(7'h00, 3'b001, rd, rs1, rs2));
			7: emit(r_type_word(7'h00, 3'b101, rd, rs1, rs2));
			8: emit(i_type_word(imm, 3'b000, rd, rs1));
			9: emit(i_type_word(imm, 3'b111, rd, rs1));
			10: emit(i_type_word(imm, 3'b110, rd, rs1));
			11: emit(i_type_word(imm, 3'b100, rd, rs1));
			default: emit(i_type_word(imm, 3'b010, rd, rs1));
		endcase
	endtask

	// Sequential ISA model, stops at the self-loop
	task automatic build_expected();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [2:0]  f3;
		logic        writes;
		logic        taken;
		trace_rec_t  rec;
		int          steps;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		expected_q.delete();
		pc = 32'h0;
		steps = 0;
		while (steps < 200) begin
			inst = prog[pc[7:2]];
			if (inst == SELF_LOOP) break;
			f3 = inst[14:12];
			a = regs[inst[19:15]];
			b = regs[inst[24:20]];
			imm = {{20{inst[31]}}, inst[31:20]};
			writes = 1'b1;
			taken = 1'b0;
			res = '0;
			case (inst[6:0])
				7'b0110011: begin
					case (f3)
						3'b000: res = inst[30] ? a - b : a + b;
						3'b111: res = a & b;
						3'b110: res = a | b;
						3'b100: res = a ^ b;
						3'b010: res = {31'b0, $signed(a) < $signed(b)};
						3'b001: res = a << b[4:0];
						3'b101: res = a >> b[4:0];
						default: writes = 1'b0;
					endcase
				end
				7'b0010011: begin
					case (f3)
						3'b000: res = a + imm;
						3'b111: res = a & imm;
						3'b110: res = a | imm;
						3'b100: res = a ^ imm;
						3'b010: res = {31'b0, $signed(a) < $signed(imm)};
						default: writes = 1'b0;
					endcase
				end
				7'b0110111: res = {inst[31:12], 12'b0};
				7'b1100011: begin
					writes = 1'b0;
					imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
					taken = (f3 == 3'b000) ? (a == b) : (a != b);
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				rec.pc = pc;
				rec.rd = inst[11:7];
				rec.data = res;
				expected_q.push_back(rec);
				// x0 traces its value but keeps reading zero
				if (inst[11:7] != 5'd0) regs[inst[11:7]] = res;
			end
			pc = taken ? pc + imm : pc + 32'd4;
			steps++;
		end
	endtask

	task automatic wait_for_ack(input logic level);
		int n;
		n = 0;
		while (load_ack != level && n < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (load_ack != level) begin
			timeout_errors++;
			$display("Timed out in %s waiting for load_ack to become %0b", test_name, level);
		end
	endtask

	// Four-phase write of one word
	task automatic load_word(input logic [`IMEM_AW-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		assert (!load_ack) else begin
			protocol_errors++;
			$display("load_ack already high before a new request in %s", test_name);
		end
		load_addr = addr;
		load_data = data;
		load_req = 1'b1;
		wait_for_ack(1'b1);
		load_req = 1'b0;
		wait_for_ack(1'b0);
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#1 rst_req = 1'b1;
		@(posedge clk);
		#1 rst_req = 1'b0;
	endtask

	// Random stalls when stall_mode is set
	task automatic execute_program(input logic stall_mode);
		int cycles;
		cycles = 0;
		@(posedge clk);
		#1 run = 1'b1;
		while (expected_q.size() != 0 && cycles < RUN_TIMEOUT) begin
			@(posedge clk);
			#1;
			if (stall_mode) run = (rand_bits(2) != 0);
			cycles++;
		end
		if (expected_q.size() != 0) begin
			timeout_errors++;
			$display("Timed out in %s with %0d retirements missing", test_name,
				expected_q.size());
		end
		// Extra cycles catch anything retiring after the self-loop
		run = 1'b1;
		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			#1;
		end
		run = 1'b0;
	endtask

	task automatic run_test(input string name, input logic stall_mode);
		test_name = name;
		pulse_reset();
		build_expected();
		for (int i = 0; i < prog_len; i++) load_word(`IMEM_AW'(i), prog[i]);
		execute_program(stall_mode);
	endtask

	// Core running, so the request must wait for run to fall
	task automatic check_held_request();
		test_name = "load_hold";
		@(posedge clk);
		#1 run = 1'b1;
		load_addr = '1;
		load_data = SELF_LOOP;
		load_req = 1'b1;
		repeat (HOLD_CYCLES) begin
			@(posedge clk);
			#1;
			if (load_ack) begin
				protocol_errors++;
				$display("load_ack given while the core was running");
			end
		end
		run = 1'b0;
		wait_for_ack(1'b1);
		load_req = 1'b0;
		wait_for_ack(1'b0);
	endtask

	// Handshake rules
	ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(load_ack) |-> $past(load_req) && !$past(run))
		else begin
			protocol_errors++;
			$display("load_ack rose without a request made while halted");
		end

	ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(load_ack) |-> !$past(load_req))
		else begin
			protocol_errors++;
			$display("load_ack fell while load_req was still high");
		end

	quiet_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
		!run |-> !trace_valid)
		else begin
			protocol_errors++;
			$display("trace_valid high while run was low");
		end

	// Retirement check, mid-cycle when trace is stable
	always @(negedge clk) begin
		if (arst_n && trace_valid) begin
			if (expected_q.size() == 0) begin
				trace_errors++;
				$display("Unexpected retirement in %s at pc %h", test_name, trace_pc);
			end else begin
				head = expected_q.pop_front();
				assert (trace_pc == head.pc && trace_rd == head.rd && trace_data == head.data)
				else begin
					trace_errors++;
					$display("FAIL %s: expected pc %h rd %0d data %h, actual pc %h rd %0d data %h",
						test_name, head.pc, head.rd, head.data, trace_pc, trace_rd, trace_data);
				end
			end
		end
	end

	initial begin
		rst_req = 1'b0;
		run = 1'b0;
		load_req = 1'b0;
		load_addr = '0;
		load_data = '0;
		trace_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;

		// Independent ops on initialized sources
		prog_len = 0;
		for (int r = 1; r <= 8; r++) emit_init(5'(r));
		repeat (24) emit_random_op(5'(9 + rand_bits(3)), 5'(1 + rand_bits(3)),
			5'(1 + rand_bits(3)));
		emit(SELF_LOOP);
		run_test("alu", 1'b0);

		// Dense dependencies over x0..x7
		prog_len = 0;
		for (int r = 1; r <= 4; r++) emit_init(5'(r));
		repeat (30) emit_random_op(5'(rand_bits(3)), 5'(rand_bits(3)), 5'(rand_bits(3)));
		emit(SELF_LOOP);
		run_test("forward", 1'b0);

		// x1 equals x2, x3 differs
		prog_len = 0;
		emit_init(5'd1);
		emit(i_type_word(12'd0, 3'b000, 5'd2, 5'd1));
		emit_init(5'd3);
		repeat (8) begin
			emit(branch_word(13'd12, {2'b00, rand_bits(1) == 1}, 5'(1 + rand_bits(2) % 3),
				5'(1 + rand_bits(2) % 3)));
			repeat (3) emit_random_op(5'(4 + rand_bits(2)), 5'(1 + rand_bits(2)),
				5'(4 + rand_bits(2)));
		end
		emit(SELF_LOOP);
		run_test("branch", 1'b0);

		// Random run toggling
		prog_len = 0;
		for (int r = 1; r <= 4; r++) emit_init(5'(r));
		repeat (40) emit_random_op(5'(rand_bits(3)), 5'(rand_bits(3)), 5'(rand_bits(3)));
		emit(SELF_LOOP);
		run_test("stall", 1'b1);

		check_held_request();

		$display("Errors: %0d trace, %0d protocol, %0d timeout", trace_errors,
			protocol_errors, timeout_errors);
		if (trace_errors + protocol_errors + timeout_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+.
rv_pkg.sv
wb_if.sv
stage_reg.sv
fetch_unit.sv
decode_stage.sv
exec_stage.sv
rv_core_top.sv
tb_clock.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rv_core
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rv_core_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
